// File: include/dot_settings.svh
`ifndef DOT_SETTINGS_SVH
`define DOT_SETTINGS_SVH

// Vector geometry.
`define DOT_WORDS 8
`define DOT_ADDR_BITS 3

// Word and keypad entry.
`define DOT_WORD_BITS 16
`define DOT_NIBBLES 4

// Display.
`define DOT_SEG_BITS 8

// Codes for the external controller.
`define DOT_STATUS_IDLE 4'd1
`define DOT_STATUS_VEC_A 4'd2
`define DOT_STATUS_VEC_B 4'd3
`define DOT_STATUS_RESULT 4'd4

`endif

// File: hw/dot_pkg.sv
`include "dot_settings.svh"

package dot_pkg;

	typedef enum logic [1:0] {
		phase_idle,
		phase_vec_a,
		phase_vec_b,
		phase_complete
	} entry_phase_e;

	// A display word is read as a value or digit by digit.
	typedef union packed {
		logic [`DOT_WORD_BITS-1:0] value;
		logic [`DOT_NIBBLES-1:0][3:0] nibble;
	} hex_word_u;

	typedef struct packed {
		logic en;
		logic bank; // 0 is vector A, 1 is vector B.
		logic [`DOT_ADDR_BITS-1:0] addr;
		logic [`DOT_WORD_BITS-1:0] data;
	} word_write_t;

	typedef struct packed {
		logic [`DOT_WORD_BITS-1:0] a;
		logic [`DOT_WORD_BITS-1:0] b;
	} operand_pair_t;

	typedef struct packed {
		hex_word_u word;
		entry_phase_e phase;
		logic [`DOT_ADDR_BITS-1:0] index;
	} entry_view_t;

	typedef struct packed {
		logic [`DOT_SEG_BITS-1:0] digit3;
		logic [`DOT_SEG_BITS-1:0] digit2;
		logic [`DOT_SEG_BITS-1:0] digit1;
		logic [`DOT_SEG_BITS-1:0] digit0;
	} seg_digits_t;

endpackage

// File: hw/entry_collector.sv
`include "dot_settings.svh"

module entry_collector (
	input  logic clk1,
	input  logic rst_n,
	input  logic key_valid,
	input  logic [3:0] key_code,
	output dot_pkg::word_write_t wr,
	output logic start,
	output dot_pkg::entry_view_t view
);

	localparam int nib_bits = $clog2(`DOT_NIBBLES);

	logic [nib_bits-1:0] nib_cnt;
	logic [`DOT_ADDR_BITS-1:0] elem_cnt;
	dot_pkg::entry_phase_e phase;
	dot_pkg::entry_phase_e key_phase;
	dot_pkg::hex_word_u word;
	dot_pkg::entry_phase_e view_phase;
	logic [`DOT_ADDR_BITS-1:0] view_index;
	logic accept;
	logic last_nibble;
	logic last_elem;
	logic last_write;

	assign accept = key_valid && (phase != dot_pkg::phase_complete); // Drop keys once full.
	assign last_nibble = (nib_cnt == (`DOT_NIBBLES - 1));
	assign last_elem = (elem_cnt == (`DOT_WORDS - 1));

	// The first key of a run already belongs to vector A.
	assign key_phase = (phase == dot_pkg::phase_idle) ? dot_pkg::phase_vec_a : phase;

	assign last_write = wr.en && wr.bank && (wr.addr == (`DOT_WORDS - 1));

	always_ff @(posedge clk1 or negedge rst_n) begin
		if (!rst_n) begin
			nib_cnt <= '0;
			elem_cnt <= '0;
			phase <= dot_pkg::phase_idle;
			word <= '0;
			view_phase <= dot_pkg::phase_idle;
			view_index <= '0;
			wr <= '0;
			start <= 1'b0;
		end else begin
			wr.en <= 1'b0;
			start <= last_write; // B7 is in memory from the next cycle on.
			if (accept) begin
				phase <= key_phase;
				view_phase <= key_phase; // View follows the element being keyed.
				view_index <= elem_cnt;
				nib_cnt <= nib_cnt + 1'b1;
				if (nib_cnt == '0) begin
					word.value <= {{(`DOT_WORD_BITS - 4){1'b0}}, key_code};
				end else begin
					word.nibble[nib_cnt] <= key_code;
				end
				if (last_nibble) begin
					wr.en <= 1'b1;
					wr.bank <= (key_phase == dot_pkg::phase_vec_b);
					wr.addr <= elem_cnt;
					wr.data <= {key_code, word.value[`DOT_WORD_BITS-5:0]};
					elem_cnt <= elem_cnt + 1'b1; // Wraps from 7 to 0 between vectors.
					if (last_elem) begin
						phase <= (key_phase == dot_pkg::phase_vec_a) ?
							dot_pkg::phase_vec_b : dot_pkg::phase_complete;
					end
				end
			end
		end
	end

	assign view.word = word;
	assign view.phase = view_phase;
	assign view.index = view_index;

endmodule

// File: hw/vector_store.sv
`include "dot_settings.svh"

module vector_store (
	input  logic clk1,
	input  logic rst_n,
	input  dot_pkg::word_write_t wr,
	input  logic [`DOT_ADDR_BITS-1:0] rd_addr,
	output dot_pkg::operand_pair_t pair
);

	// Bank 0 holds vector A, bank 1 holds vector B.
	logic [`DOT_WORD_BITS-1:0] mem [2][`DOT_WORDS];

	always_ff @(posedge clk1 or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < `DOT_WORDS; i++) begin
					mem[b][i] <= '0;
				end
			end
		end else if (wr.en) begin
			mem[wr.bank][wr.addr] <= wr.data;
		end
	end

	// Both operands at the same address, no read latency.
	assign pair.a = mem[0][rd_addr];
	assign pair.b = mem[1][rd_addr];

endmodule

// File: hw/mac_engine.sv
`include "dot_settings.svh"

module mac_engine (
	input  logic clk1,
	input  logic rst_n,
	input  logic start,
	output logic [`DOT_ADDR_BITS-1:0] rd_addr,
	input  dot_pkg::operand_pair_t pair,
	output logic [`DOT_WORD_BITS-1:0] result,
	output logic done
);

	logic [`DOT_ADDR_BITS-1:0] addr_cnt;
	logic busy;
	logic last_addr;
	logic [`DOT_WORD_BITS-1:0] product;
	logic [`DOT_WORD_BITS-1:0] acc;

	assign last_addr = (addr_cnt == (`DOT_WORDS - 1));

	// Only the low half of each product reaches the sum.
	assign product = pair.a * pair.b;

	always_ff @(posedge clk1 or negedge rst_n) begin
		if (!rst_n) begin
			addr_cnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			acc <= '0;
		end else if (busy) begin
			acc <= acc + product; // Wraps mod 2^16.
			addr_cnt <= addr_cnt + 1'b1;
			if (last_addr) begin
				busy <= 1'b0;
				done <= 1'b1; // Held until reset.
			end
		end else if (start && !done) begin
			busy <= 1'b1;
			addr_cnt <= '0;
			acc <= '0;
		end
	end

	assign rd_addr = addr_cnt;
	assign result = acc;

endmodule

// File: hw/display_driver.sv
`include "dot_settings.svh"

module display_driver (
	input  dot_pkg::entry_view_t view,
	input  logic [`DOT_WORD_BITS-1:0] result,
	input  logic done,
	output dot_pkg::seg_digits_t segments,
	output logic [`DOT_WORDS-1:0] tracker,
	output logic [3:0] status
);

	dot_pkg::hex_word_u shown;

	// Active low, decimal point off.
	function automatic logic [`DOT_SEG_BITS-1:0] seg_of(input logic [3:0] nib);
		logic [`DOT_SEG_BITS-1:0] pat;
		case (nib)
			4'h0: pat = 8'hc0;
			4'h1: pat = 8'hf9;
			4'h2: pat = 8'ha4;
			4'h3: pat = 8'hb0;
			4'h4: pat = 8'h99;
			4'h5: pat = 8'h92;
			4'h6: pat = 8'h82;
			4'h7: pat = 8'hf8;
			4'h8: pat = 8'h80;
			4'h9: pat = 8'h98;
			4'ha: pat = 8'h88;
			4'hb: pat = 8'h83;
			4'hc: pat = 8'hc6;
			4'hd: pat = 8'ha1;
			4'he: pat = 8'h86;
			default: pat = 8'h8e;
		endcase
		return pat;
	endfunction

	always_comb begin
		shown.value = done ? result : view.word.value;
		segments.digit0 = seg_of(shown.nibble[0]);
		segments.digit1 = seg_of(shown.nibble[1]);
		segments.digit2 = seg_of(shown.nibble[2]);
		segments.digit3 = seg_of(shown.nibble[3]);
	end

	always_comb begin
		tracker = '1;
		status = `DOT_STATUS_IDLE;
		if (done) begin
			status = `DOT_STATUS_RESULT;
		end else begin
			case (view.phase)
				dot_pkg::phase_vec_a: begin
					tracker = ~(`DOT_WORDS'(1) << view.index); // One-cold element marker.
					status = `DOT_STATUS_VEC_A;
				end
				dot_pkg::phase_vec_b: begin
					tracker = ~(`DOT_WORDS'(1) << view.index);
					status = `DOT_STATUS_VEC_B;
				end
				dot_pkg::phase_complete: status = `DOT_STATUS_VEC_B; // Waiting on the MAC.
				default: status = `DOT_STATUS_IDLE;
			endcase
		end
	end

endmodule

// File: hw/dot_product_top.sv
`include "dot_settings.svh"

module dot_product_top (
	input  logic clk1,
	input  logic rst_n,
	input  logic key_valid,
	input  logic [3:0] key_code,
	output dot_pkg::seg_digits_t segments,
	output logic [`DOT_WORDS-1:0] tracker,
	output logic [3:0] status
);

	dot_pkg::word_write_t wr;
	dot_pkg::entry_view_t view;
	dot_pkg::operand_pair_t pair;
	logic start;
	logic [`DOT_ADDR_BITS-1:0] rd_addr;
	logic [`DOT_WORD_BITS-1:0] result;
	logic done;

	// Keypad side.
	entry_collector u_entry_collector (
		.clk1      (clk1),
		.rst_n     (rst_n),
		.key_valid (key_valid),
		.key_code  (key_code),
		.wr        (wr),
		.start     (start),
		.view      (view)
	);

	vector_store u_vector_store (
		.clk1    (clk1),
		.rst_n   (rst_n),
		.wr      (wr),
		.rd_addr (rd_addr),
		.pair    (pair)
	);

	mac_engine u_mac_engine (
		.clk1    (clk1),
		.rst_n   (rst_n),
		.start   (start),
		.rd_addr (rd_addr),
		.pair    (pair),
		.result  (result),
		.done    (done)
	);

	// Display side.
	display_driver u_display_driver (
		.view     (view),
		.result   (result),
		.done     (done),
		.segments (segments),
		.tracker  (tracker),
		.status   (status)
	);

endmodule

// File: test/tb_dot_product.sv
`include "dot_settings.svh"

module tb_dot_product;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_sets = 2;
	localparam int max_cycles = 2000 * num_sets;

	logic clk1;
	logic rst_n;
	logic key_valid;
	logic [3:0] key_code;
	dot_pkg::seg_digits_t segments;
	logic [`DOT_WORDS-1:0] tracker;
	logic [3:0] status;

	dot_pkg::seg_digits_t exp_segments;
	logic [`DOT_WORDS-1:0] exp_tracker;
	logic [3:0] exp_status;
	string check_name;
	event check_ev;
	int check_count = 0;
	int mismatch_count = 0;
	int other_count = 0;
	int cycle_count = 0;
	logic [`DOT_WORDS-1:0][`DOT_WORD_BITS-1:0] vec_a;
	logic [`DOT_WORDS-1:0][`DOT_WORD_BITS-1:0] vec_b;

	dot_product_top dut (
		.clk1      (clk1),
		.rst_n     (rst_n),
		.key_valid (key_valid),
		.key_code  (key_code),
		.segments  (segments),
		.tracker   (tracker),
		.status    (status)
	);

	always #4 clk1 = ~clk1;

	// Active low, decimal point off.
	function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'hc0;
			4'h1: return 8'hf9;
			4'h2: return 8'ha4;
			4'h3: return 8'hb0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hf8;
			4'h8: return 8'h80;
			4'h9: return 8'h98;
			4'ha: return 8'h88;
			4'hb: return 8'h83;
			4'hc: return 8'hc6;
			4'hd: return 8'ha1;
			4'he: return 8'h86;
			default: return 8'h8e;
		endcase
	endfunction

	// Nibbles not yet keyed read as zero.
	function automatic dot_pkg::seg_digits_t digits_of(input logic [15:0] word, input int keyed);
		dot_pkg::seg_digits_t segs;
		logic [15:0] shown;
		shown = '0;
		for (int n = 0; n < 4; n++) begin
			if (n < keyed) shown[4*n +: 4] = word[4*n +: 4];
		end
		segs.digit0 = seg_pattern(shown[3:0]);
		segs.digit1 = seg_pattern(shown[7:4]);
		segs.digit2 = seg_pattern(shown[11:8]);
		segs.digit3 = seg_pattern(shown[15:12]);
		return segs;
	endfunction

	function automatic logic [7:0] tracker_of(input int index);
		return ~(8'b1 << index); // One-cold.
	endfunction

	function automatic logic [15:0] dot_ref(input logic [7:0][15:0] va,
			input logic [7:0][15:0] vb);
		logic [15:0] acc;
		logic [31:0] prod;
		acc = '0;
		for (int i = 0; i < 8; i++) begin
			prod = va[i] * vb[i];
			acc = acc + prod[15:0]; // Wraps mod 2^16.
		end
		return acc;
	endfunction

	task automatic expect_outputs(input dot_pkg::seg_digits_t segs, input logic [7:0] trk,
			input logic [3:0] st, input string name);
		exp_segments = segs;
		exp_tracker = trk;
		exp_status = st;
		check_name = name;
		-> check_ev;
	endtask

	// Called on a falling edge; returns on the next one.
	task automatic press_key(input logic [3:0] code);
		key_valid = 1'b1;
		key_code = code;
		@(negedge clk1);
		key_valid = 1'b0;
		key_code = '0;
	endtask

	task automatic idle_gap;
		int gap;
		gap = $urandom_range(3, 0);
		repeat (gap) @(negedge clk1);
	endtask

	task automatic apply_reset;
		rst_n = 1'b0;
		repeat (2) @(negedge clk1);
		rst_n = 1'b1;
	endtask

	task automatic run_set(input string name);
		logic [15:0] word;
		dot_pkg::seg_digits_t result_segs;
		for (int e = 0; e < 16; e++) begin
			word = (e < 8) ? vec_a[e] : vec_b[e-8];
			for (int n = 0; n < 4; n++) begin
				press_key(word[4*n +: 4]);
				expect_outputs(digits_of(word, n + 1), tracker_of(e % 8),
					(e < 8) ? `DOT_STATUS_VEC_A : `DOT_STATUS_VEC_B,
					$sformatf("%s element %0d nibble %0d", name, e, n));
				if (e < 15 || n < 3) begin
					idle_gap();
				end
			end
		end
		// The MAC is still running, so an accepted key would show on the digits.
		for (int k = 0; k < 2; k++) begin
			press_key(4'($urandom));
			expect_outputs(digits_of(word, 4), tracker_of(7), `DOT_STATUS_VEC_B,
				$sformatf("%s key %0d while computing", name, k));
		end
		while (status !== `DOT_STATUS_RESULT) @(negedge clk1); // Bounded by the cycle counter.
		result_segs = digits_of(dot_ref(vec_a, vec_b), 4);
		expect_outputs(result_segs, 8'hff, `DOT_STATUS_RESULT, {name, " result"});
		for (int k = 0; k < 3; k++) begin
			press_key(4'($urandom));
			expect_outputs(result_segs, 8'hff, `DOT_STATUS_RESULT,
				$sformatf("%s key %0d after completion", name, k));
			idle_gap();
		end
	endtask

	task automatic print_counts;
		$display("Checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_count);
	endtask

	always @(check_ev) begin
		check_count++;
		assert (segments === exp_segments) else begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s digits %h, expected %h",
				$time, check_name, segments, exp_segments);
		end
		assert (tracker === exp_tracker) else begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s tracker %h, expected %h",
				$time, check_name, tracker, exp_tracker);
		end
		assert (status === exp_status) else begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s status %0d, expected %0d",
				$time, check_name, status, exp_status);
		end
	end

	always @(posedge clk1) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			other_count++;
			$display("Timeout: the run did not finish within %0d cycles.", max_cycles);
			print_counts();
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		clk1 = 1'b0;
		rst_n = 1'b0;
		key_valid = 1'b0;
		key_code = '0;
		void'($urandom(32'hd7782fbc));

		// All-F words, every product truncates.
		for (int i = 0; i < 8; i++) begin
			vec_a[i] = 16'hffff;
			vec_b[i] = 16'hffff;
		end
		apply_reset();
		@(negedge clk1);
		expect_outputs(digits_of(16'h0, 4), 8'hff, `DOT_STATUS_IDLE, "first reset");
		run_set("all-F");

		for (int i = 0; i < 8; i++) begin
			vec_a[i] = 16'($urandom);
			vec_b[i] = 16'($urandom);
		end
		apply_reset();
		@(negedge clk1);
		expect_outputs(digits_of(16'h0, 4), 8'hff, `DOT_STATUS_IDLE, "second reset");
		run_set("random");

		@(negedge clk1);
		print_counts();
		if (mismatch_count == 0 && other_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
hw/dot_pkg.sv
hw/entry_collector.sv
hw/vector_store.sv
hw/mac_engine.sv
hw/display_driver.sv
hw/dot_product_top.sv
test/tb_dot_product.sv
